/* compile.f */
mem_pkg.sv
mem_lsu.sv
data_ram.sv
mem_wb_reg.sv
mem_stage.sv
tb_mem_stage.sv

/* data_ram.sv */
`timescale 1ns/100ps

module data_ram (
  input  logic                          clk,
  input  mem_pkg::ram_wr_t              ram_wr_i,
  input  logic [mem_pkg::addr_w-1:0]    rd_addr_i,
  output logic [mem_pkg::bus_w-1:0]     rd_data_o
);

  logic [mem_pkg::xlen-1:0]   mem_q [mem_pkg::ram_depth];
  logic [mem_pkg::ram_aw-1:0] wr_idx;
  logic [mem_pkg::ram_aw-1:0] rd_idx;

  // word index from bits 9:2 so higher bits wrap.
  assign wr_idx = ram_wr_i.addr[mem_pkg::ram_aw+1:2];
  assign rd_idx = rd_addr_i[mem_pkg::ram_aw+1:2];

  // byte-lane write for the four low strobe bits.
  always_ff @(posedge clk) begin
    for (int b = 0; b < mem_pkg::xlen / 8; b++) begin
      if (ram_wr_i.wstrb[b]) begin
        mem_q[wr_idx][8*b +: 8] <= ram_wr_i.wdata[8*b +: 8];
      end
    end
  end

  // async read with zeros above the word.
  assign rd_data_o = {{(mem_pkg::bus_w - mem_pkg::xlen){1'b0}}, mem_q[rd_idx]};

endmodule

/* mem_lsu.sv */
`timescale 1ns/100ps

module mem_lsu (
  input  mem_pkg::mem_req_t               req_i,
  input  logic [mem_pkg::bus_w-1:0]       rd_data_i,
  output logic [mem_pkg::addr_w-1:0]      rd_addr_o,
  output mem_pkg::ram_wr_t                ram_wr_o,
  output logic [mem_pkg::xlen-1:0]        load_data_o
);

  logic [mem_pkg::addr_w-1:0] eff_addr;
  logic [1:0]                 byte_off;
  logic                       is_load;
  logic                       is_store;
  logic [mem_pkg::strb_w-1:0] wstrb;
  logic [mem_pkg::xlen-1:0]   rd_word;
  logic [mem_pkg::xlen-1:0]   shift_data;
  logic [mem_pkg::xlen-1:0]   load_data;

  // effective address, shared by loads and stores.
  assign eff_addr = req_i.rdata1 + req_i.imm;
  assign byte_off = eff_addr[1:0];

  assign is_load  = (req_i.inst_type == mem_pkg::inst_load);
  assign is_store = (req_i.inst_type == mem_pkg::inst_store);

  // read side.
  assign rd_addr_o = is_load ? eff_addr : '0;

  // write side, only live for stores.
  assign ram_wr_o.addr  = is_store ? eff_addr : '0;
  assign ram_wr_o.wdata = is_store ? {{(mem_pkg::bus_w - mem_pkg::xlen){1'b0}}, req_i.rdata2}
                                   : '0;
  assign ram_wr_o.wstrb = wstrb;

  // byte strobes by size and offset.
  // accesses crossing the word boundary write nothing.
  always_comb begin
    wstrb = '0;
    if (is_store) begin
      case (req_i.lsu_op)
        mem_pkg::op_sb: begin
          wstrb = 8'b0000_0001 << byte_off;
        end
        mem_pkg::op_sh: begin
          if (byte_off != 2'd3) begin
            wstrb = 8'b0000_0011 << byte_off;
          end
        end
        mem_pkg::op_sw: begin
          if (byte_off == 2'd0) begin
            wstrb = 8'b0000_1111;
          end
        end
        default: begin
          wstrb = '0;
        end
      endcase
    end
  end

  // RAM word sits in the low half of the bus.
  assign rd_word = rd_data_i[mem_pkg::xlen-1:0];

  // shift right by the byte offset, zero fill from the top.
  always_comb begin
    case (byte_off)
      2'd0:    shift_data = rd_word;
      2'd1:    shift_data = {8'h00, rd_word[31:8]};
      2'd2:    shift_data = {16'h0000, rd_word[31:16]};
      default: shift_data = {24'h00_0000, rd_word[31:24]};
    endcase
  end

  // extension per load op.
  always_comb begin
    load_data = '0;
    if (is_load) begin
      case (req_i.lsu_op)
        mem_pkg::op_lb: begin
          load_data = {{24{shift_data[7]}}, shift_data[7:0]};
        end
        mem_pkg::op_lh: begin
          load_data = {{16{shift_data[15]}}, shift_data[15:0]};
        end
        mem_pkg::op_lw: begin
          load_data = shift_data;
        end
        mem_pkg::op_lbu: begin
          load_data = {24'h00_0000, shift_data[7:0]};
        end
        mem_pkg::op_lhu: begin
          load_data = {16'h0000, shift_data[15:0]};
        end
        default: begin
          load_data = '0;
        end
      endcase
    end
  end

  assign load_data_o = load_data;

endmodule

/* mem_pkg.sv */
package mem_pkg;

  // datapath widths.
  localparam int xlen   = 32;
  localparam int addr_w = 32;
  localparam int bus_w  = 64;
  localparam int strb_w = 8;

  // data RAM geometry, in 32-bit words.
  localparam int ram_depth = 256;
  localparam int ram_aw    = 8;

  // instruction class from decode.
  typedef enum logic [1:0] {
    inst_none  = 2'b00,
    inst_load  = 2'b01,
    inst_store = 2'b10
  } inst_type_t;

  // load/store operation.
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_lbu  = 4'd4,
    op_lhu  = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } lsu_op_t;

  // request from the execute stage.
  typedef struct packed {
    inst_type_t        inst_type;
    lsu_op_t           lsu_op;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   rdata1;
    logic [xlen-1:0]   rdata2;
    logic [4:0]        rd;
  } mem_req_t;

  // write command towards the data RAM.
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [bus_w-1:0]  wdata;
    logic [strb_w-1:0] wstrb;
  } ram_wr_t;

  // result handed to writeback.
  typedef struct packed {
    logic              valid;
    logic [4:0]        rd;
    logic [xlen-1:0]   data;
  } wb_t;

endpackage

/* mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
  input  logic                  clk,
  input  logic                  reset_i,
  input  mem_pkg::mem_req_t     req_i,
  output mem_pkg::wb_t          wb_o
);

  mem_pkg::ram_wr_t             ram_wr;
  logic [mem_pkg::addr_w-1:0]   rd_addr;
  logic [mem_pkg::bus_w-1:0]    rd_data;
  logic [mem_pkg::xlen-1:0]     load_data;

  // address, strobes and load alignment.
  mem_lsu mem_lsu_i (
    .req_i       (req_i),
    .rd_data_i   (rd_data),
    .rd_addr_o   (rd_addr),
    .ram_wr_o    (ram_wr),
    .load_data_o (load_data)
  );

  data_ram data_ram_i (
    .clk       (clk),
    .ram_wr_i  (ram_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  // one cycle to writeback.
  mem_wb_reg mem_wb_reg_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .load_data_i (load_data),
    .wb_o        (wb_o)
  );

endmodule

/* mem_wb_reg.sv */
`timescale 1ns/100ps

module mem_wb_reg (
  input  logic                          clk,
  input  logic                          reset_i,
  input  mem_pkg::mem_req_t             req_i,
  input  logic [mem_pkg::xlen-1:0]      load_data_i,
  output mem_pkg::wb_t                  wb_o
);

  logic                     valid_q;
  logic [4:0]               rd_q;
  logic [mem_pkg::xlen-1:0] data_q;

  // only loads produce a writeback.
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= (req_i.inst_type == mem_pkg::inst_load);
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= req_i.rd;
    data_q <= load_data_i;
  end

  assign wb_o.valid = valid_q;
  assign wb_o.rd    = rd_q;
  assign wb_o.data  = data_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_mem_stage
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_mem_stage 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -q 'All tests passed!'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb_mem_stage.sv */
`timescale 1ns/100ps

module tb_mem_stage;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 8;
  localparam int fill_cycles  = mem_pkg::ram_depth;
  localparam int directed_max = 64;
  localparam int random_reqs  = 300;
  localparam int margin       = 100;
  localparam int total_cycles = reset_cycles + fill_cycles + directed_max + random_reqs + margin;

  logic              clk = 1'b0;
  logic              reset_i;
  mem_pkg::mem_req_t req;
  mem_pkg::wb_t      wb;
  mem_pkg::wb_t      exp_wb;
  mem_pkg::wb_t      exp_q [$];
  logic [7:0]        shadow [1024];
  logic [31:0]       lfsr;

  mem_pkg::lsu_op_t load_ops [5] = '{mem_pkg::op_lb, mem_pkg::op_lh, mem_pkg::op_lw,
                                     mem_pkg::op_lbu, mem_pkg::op_lhu};
  mem_pkg::lsu_op_t store_ops [3] = '{mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw};

  mem_stage mem_stage_i (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req),
    .wb_o    (wb)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // 32-bit fibonacci lfsr with taps 32 22 2 1.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // word shifted down by the byte offset and then extended.
  function automatic logic [31:0] model_load(input mem_pkg::lsu_op_t op,
                                             input logic [31:0] addr);
    logic [9:0]  base;
    logic [31:0] word;
    logic [31:0] sh;
    base = {addr[9:2], 2'b00};
    word = {shadow[base + 10'd3], shadow[base + 10'd2], shadow[base + 10'd1], shadow[base]};
    sh   = word >> (8 * addr[1:0]);
    case (op)
      mem_pkg::op_lb:  return {{24{sh[7]}}, sh[7:0]};
      mem_pkg::op_lh:  return {{16{sh[15]}}, sh[15:0]};
      mem_pkg::op_lw:  return sh;
      mem_pkg::op_lbu: return {24'h00_0000, sh[7:0]};
      mem_pkg::op_lhu: return {16'h0000, sh[15:0]};
      default:         return '0;
    endcase
  endfunction

  // lane b takes byte b of the store data; word crossings write nothing.
  function automatic void model_store(input mem_pkg::lsu_op_t op, input logic [31:0] addr,
                                      input logic [31:0] data);
    logic [3:0] lanes;
    logic [1:0] k;
    logic [9:0] base;
    k     = addr[1:0];
    base  = {addr[9:2], 2'b00};
    lanes = 4'b0000;
    if (op == mem_pkg::op_sb) begin
      lanes = 4'b0001 << k;
    end else if (op == mem_pkg::op_sh && k != 2'd3) begin
      lanes = 4'b0011 << k;
    end else if (op == mem_pkg::op_sw && k == 2'd0) begin
      lanes = 4'b1111;
    end
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        shadow[base + 10'(b)] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic stop_on_error();
    $display("Test failures found");
    $fatal(1, "stopped at the first failing check");
  endtask

  // expectation lands in exp_wb one edge after its request.
  task automatic present(input mem_pkg::inst_type_t itype, input mem_pkg::lsu_op_t op,
                         input logic [31:0] base, input logic [31:0] imm,
                         input logic [31:0] data, input logic [4:0] rd);
    mem_pkg::mem_req_t r;
    mem_pkg::wb_t      e;
    logic [31:0]       addr;
    r.inst_type = itype;
    r.lsu_op    = op;
    r.imm       = imm;
    r.rdata1    = base;
    r.rdata2    = data;
    r.rd        = rd;
    addr        = base + imm;
    e.valid     = (itype == mem_pkg::inst_load);
    e.rd        = rd;
    e.data      = e.valid ? model_load(op, addr) : '0;
    if (itype == mem_pkg::inst_store) begin
      model_store(op, addr, data);
    end
    @(posedge clk);
    req <= r;
    exp_q.push_back(e);
    if (exp_q.size() > 1) begin
      exp_wb <= exp_q.pop_front();
    end
  endtask

  task automatic write_mem(input mem_pkg::lsu_op_t op, input logic [31:0] addr,
                           input logic [31:0] data);
    present(mem_pkg::inst_store, op, addr, 32'h0, data, 5'd0);
  endtask

  task automatic read_mem(input mem_pkg::lsu_op_t op, input logic [31:0] addr,
                          input logic [4:0] rd);
    present(mem_pkg::inst_load, op, addr, 32'h0, 32'h0, rd);
  endtask

  check_valid: assert property (@(negedge clk) wb.valid == exp_wb.valid)
    else begin
      $display("ERROR: wb_o.valid expected 0x%0h got 0x%0h", exp_wb.valid, wb.valid);
      stop_on_error();
    end

  check_rd: assert property (@(negedge clk) !exp_wb.valid || wb.rd == exp_wb.rd)
    else begin
      $display("ERROR: wb_o.rd expected 0x%02h got 0x%02h", exp_wb.rd, wb.rd);
      stop_on_error();
    end

  check_data: assert property (@(negedge clk) !exp_wb.valid || wb.data == exp_wb.data)
    else begin
      $display("ERROR: wb_o.data expected 0x%08h got 0x%08h", exp_wb.data, wb.data);
      stop_on_error();
    end

  initial begin
    #(total_cycles * clk_period);
    $display("timeout: the test sequence did not finish within %0d cycles", total_cycles);
    stop_on_error();
  end

  initial begin
    mem_pkg::mem_req_t reset_req;
    logic [7:0]  idx;
    logic [1:0]  sel;
    logic [31:0] a;
    logic [31:0] imm;
    logic [31:0] data;
    logic [4:0]  rd;
    reset_req           = '0;
    reset_req.inst_type = mem_pkg::inst_load;
    reset_req.lsu_op    = mem_pkg::op_lw;
    reset_req.rd        = 5'd7;
    // a load held through reset must not reach writeback.
    reset_i <= 1'b1;
    req     <= reset_req;
    exp_wb  <= '0;
    lfsr     = 32'd66722;
    repeat (reset_cycles) @(posedge clk);
    reset_i <= 1'b0;
    req     <= '0;

    // every word gets a pattern built from its own index.
    for (int i = 0; i < mem_pkg::ram_depth; i++) begin
      idx = 8'(i);
      write_mem(mem_pkg::op_sw, 32'(i * 4), {idx ^ 8'ha5, ~idx, idx + 8'h3c, idx});
    end

    for (int k = 0; k < 4; k++) begin
      write_mem(mem_pkg::op_sb, 32'h40 + 32'(k), rand_bits(32));
    end
    read_mem(mem_pkg::op_lw, 32'h40, 5'd1);
    write_mem(mem_pkg::op_sh, 32'h44, rand_bits(32));
    write_mem(mem_pkg::op_sh, 32'h46, rand_bits(32));
    read_mem(mem_pkg::op_lw, 32'h44, 5'd2);
    write_mem(mem_pkg::op_sw, 32'h48, rand_bits(32));
    read_mem(mem_pkg::op_lw, 32'h48, 5'd3);

    // bytes and halves with the top bit both set and clear.
    write_mem(mem_pkg::op_sw, 32'h50, 32'h80f1_7f01);
    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 5; j++) begin
        read_mem(load_ops[j], 32'h50 + 32'(k), 5'(rand_bits(5)));
      end
    end

    write_mem(mem_pkg::op_sw, 32'h60, 32'h1122_3344);
    write_mem(mem_pkg::op_sh, 32'h63, 32'hdead_beef);
    for (int k = 1; k < 4; k++) begin
      write_mem(mem_pkg::op_sw, 32'h60 + 32'(k), 32'hcafe_f00d);
    end
    read_mem(mem_pkg::op_lw, 32'h60, 5'd9);

    // random mix with base up to 4 KB so the index wraps.
    for (int n = 0; n < random_reqs; n++) begin
      sel  = 2'(rand_bits(2));
      a    = rand_bits(12);
      imm  = rand_bits(4);
      data = rand_bits(32);
      rd   = 5'(rand_bits(5));
      case (sel)
        2'd0: present(mem_pkg::inst_none, mem_pkg::op_none, a, imm, data, rd);
        2'd1: present(mem_pkg::inst_load, load_ops[rand_bits(3) % 5], a, imm, data, rd);
        default: present(mem_pkg::inst_store, store_ops[rand_bits(2) % 3], a, imm, data, rd);
      endcase
    end

    // bubbles flush the last expectation through.
    present(mem_pkg::inst_none, mem_pkg::op_none, 32'h0, 32'h0, 32'h0, 5'd0);
    present(mem_pkg::inst_none, mem_pkg::op_none, 32'h0, 32'h0, 32'h0, 5'd0);
    repeat (2) @(posedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule
